// File: la_top.f
la_pkg.sv
la_sampler.sv
la_ring_ram.sv
ctrl.sv
la_uart_tx.sv
la_top.sv
la_assert.sv
tb_la_top.sv

// File: run.sh
#!/bin/sh
# build the la_top testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f la_top.f --top-module tb_la_top -o tb_la_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_la_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "STATUS: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: tb_la_top.sv
// tb_la_top: clock, reset, stimulus, uart frame monitor, reference function and checks
`default_nettype none
`timescale 1ns/100ps

module tb_la_top import la_pkg::*; ;

  localparam int NTESTS   = 6;
  localparam int IDLE_CYC = 200;                 // > 32 strobes, ring fully refilled
  // worst case per test, dly 3 and rd 11, 12 bit times per frame
  localparam int TEST_CYC = IDLE_CYC + (3 + 3) * 4 * SAMPLE_DIV
                          + (4 * 11 + 4) * 12 * BAUD_DIV;
  localparam int TIMEOUT_CYC = (NTESTS + 1) * TEST_CYC + 500;

  logic                clk_i;
  logic                rst_in;
  logic [SAMPLE_W-1:0] probe_i;
  cnt_cfg_t            cmd_i;
  logic                set_cnt_i;
  logic                run_i;
  logic                tx_o;
  logic                busy_o;

  int                  cyc = 0;                  // clock cycles since start
  int                  err_cnt = 0;
  logic [31:0]         lfsr_q = 32'h93f6_7df5;
  logic [7:0]          rx_q[$];                  // bytes of the current readout

  la_top dut_i (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .probe_i   (probe_i),
    .cmd_i     (cmd_i),
    .set_cnt_i (set_cnt_i),
    .run_i     (run_i),
    .tx_o      (tx_o),
    .busy_o    (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;                  // 100 ns period
  end

  always @(negedge clk_i) probe_i <= probe_i + 1'b1;   // probe counts every clock

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc > TIMEOUT_CYC) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    if (got !== want) begin
      err_cnt++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
      $display("STATUS: FAIL");
      $fatal(1, "check %s failed", name);
    end
  endtask

  // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_random_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);                // one step per bit
      v = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // byte k of a readout, newest first, one entry per SAMPLE_DIV clocks, 32 entries
  function automatic logic [7:0] ref_byte(input logic [7:0] first, input int k);
    return first - 8'(SAMPLE_DIV * (k % 32));
  endfunction

  task automatic load_counts(input int dly, input int rd);
    cmd_i.dly_cnt = CNT_W'(dly);
    cmd_i.rd_cnt  = CNT_W'(rd);
    set_cnt_i = 1'b1;
    @(negedge clk_i);
    set_cnt_i = 1'b0;
  endtask

  // line quiet and core idle for n cycles
  task automatic expect_idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      compare_values("tx_o while idle", tx_o, 1);
      compare_values("busy_o while idle", busy_o, 0);
    end
  endtask

  // frame monitor, samples tx_o mid-bit on falling edges
  initial begin : frame_monitor
    logic [7:0] rx;
    int         last_start;
    last_start = -(20 * BAUD_DIV);
    forever begin
      @(negedge clk_i);
      if (rst_in === 1'b1 && tx_o === 1'b0) begin
        // full stop bit since the previous frame
        compare_values("frame spacing ok", (cyc - last_start >= 10 * BAUD_DIV), 1);
        compare_values("busy_o at frame start", busy_o, 1);
        last_start = cyc;
        repeat (BAUD_DIV / 2 - 1) @(negedge clk_i);
        compare_values("tx_o start bit", tx_o, 0);
        for (int i = 0; i < SAMPLE_W; i++) begin
          repeat (BAUD_DIV) @(negedge clk_i);
          rx[i] = tx_o;                          // lsb first
        end
        repeat (BAUD_DIV) @(negedge clk_i);
        compare_values("tx_o stop bit", tx_o, 1);
        rx_q.push_back(rx);
      end
    end
  end

  initial begin : stimulus
    int         d, r, dd, rr, lo, hi;
    logic [7:0] first, run_probe, off;
    rst_in    = 1'b0;
    run_i     = 1'b0;
    set_cnt_i = 1'b0;
    cmd_i     = '0;
    probe_i  <= '0;
    repeat (5) @(negedge clk_i);
    rst_in = 1'b1;
    @(negedge clk_i);
    compare_values("tx_o after reset", tx_o, 1);
    compare_values("busy_o after reset", busy_o, 0);
    load_counts(3, 11);                          // no run, nothing may happen
    expect_idle(100);
    compare_values("frames without run", rx_q.size(), 0);

    for (int t = 0; t < NTESTS; t++) begin
      take_random_bits(2, dd);
      take_random_bits(4, rr);
      load_counts(dd, rr % 12);                  // decoy, overwritten after run
      expect_idle(IDLE_CYC);
      take_random_bits(2, d);
      take_random_bits(4, r);
      r = r % 12;
      if (t == NTESTS - 1) r = 11;               // 48 frames, wraps the ring
      run_i = 1'b1;
      @(posedge clk_i);
      run_probe = probe_i;                       // probe seen with run_i
      @(negedge clk_i);
      run_i = 1'b0;
      compare_values("busy_o after run", busy_o, 1);
      load_counts(d, r);                         // new counts while busy
      while (rx_q.size() == 0) @(negedge clk_i);
      load_counts(d, r);                         // relatch mid readout
      while (busy_o) @(negedge clk_i);

      compare_values("frame count", rx_q.size(), 4 * r + 4);
      first = rx_q[0];
      // sample register delay plus strobe phase after the run cycle
      off = first - run_probe;
      lo  = SAMPLE_DIV * (4 * d + 5);
      hi  = SAMPLE_DIV * (4 * d + 7) - 1;
      compare_values("trigger offset in window", (int'(off) >= lo && int'(off) <= hi), 1);
      for (int k = 0; k < rx_q.size(); k++) begin
        compare_values("rx byte", rx_q[k], ref_byte(first, k));
      end
      rx_q.delete();
    end
    expect_idle(IDLE_CYC);                       // no stray frame after last readout
    compare_values("frames after last readout", rx_q.size(), 0);

    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: la_assert.sv
// la_assert_chk: concurrent checks for ctrl and la_uart_tx, plus their bind statements
`default_nettype none
`timescale 1ns/100ps

module la_assert_chk (
  input wire logic       clk_i,
  input wire logic       rst_in,
  input wire logic       stb_i,        // frame strobe
  input wire logic       rdy_i,        // transmitter ready
  input wire logic       we_i,         // ring write enable
  input wire logic       tx_phase_i,   // ctrl in TX or TX_WAIT
  input wire logic       idle_i,       // transmitter idle
  input wire logic       line_i,       // serial line
  input wire logic [1:0] state_i       // fsm state
);

  // strobe only honored while ready
  stb_when_rdy: assert property (@(posedge clk_i) disable iff (!rst_in) stb_i |-> rdy_i)
    else $error("frame strobe while transmitter not ready");

  no_write_in_tx: assert property (@(posedge clk_i) disable iff (!rst_in) we_i |-> !tx_phase_i)
    else $error("ring write during readout");

  line_idle_high: assert property (@(posedge clk_i) disable iff (!rst_in) idle_i |-> line_i)
    else $error("serial line low while transmitter idle");

  // all four codes are used, so known means legal
  state_legal: assert property (@(posedge clk_i) disable iff (!rst_in) !$isunknown(state_i))
    else $error("fsm state unknown");

endmodule

bind ctrl la_assert_chk ctrl_chk_i (
  .clk_i      (clk_i),
  .rst_in     (rst_in),
  .stb_i      (tx_stb_o),
  .rdy_i      (tx_rdy_i),
  .we_i       (we_o),
  .tx_phase_i (state_q[1]),            // TX and TX_WAIT share the upper bit
  .idle_i     (1'b0),
  .line_i     (1'b1),
  .state_i    (state_q)
);

bind la_uart_tx la_assert_chk uart_chk_i (
  .clk_i      (clk_i),
  .rst_in     (rst_in),
  .stb_i      (stb_i),
  .rdy_i      (rdy_o),
  .we_i       (1'b0),
  .tx_phase_i (1'b0),
  .idle_i     (rdy_o),                 // rdy_o is high only in U_IDLE
  .line_i     (tx_o),
  .state_i    (state_q)
);

`default_nettype wire

// File: la_top.sv
// la_top: logic analyzer top, sampler, ring, ctrl and uart transmitter
`default_nettype none
`timescale 1ns/100ps

module la_top import la_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_in,     // sync, active low
  input  wire logic [SAMPLE_W-1:0] probe_i,    // sampled bus
  input  wire cnt_cfg_t            cmd_i,      // count command word
  input  wire logic                set_cnt_i,  // latch cmd_i
  input  wire logic                run_i,      // trigger
  output logic                     tx_o,       // serial out
  output logic                     busy_o      // capture or readout active
);

  logic                stb;                    // sample strobe
  logic [SAMPLE_W-1:0] sample;
  logic                we;
  logic [DEPTH-1:0]    addr;                   // shared ring address
  logic [SAMPLE_W-1:0] rd_data;
  logic                tx_stb;
  logic                tx_rdy;

  la_sampler sampler_i (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .probe_i  (probe_i),
    .stb_o    (stb),
    .sample_o (sample)
  );

  la_ring_ram ring_i (
    .clk_i   (clk_i),
    .we_i    (we),
    .waddr_i (addr),
    .wdata_i (sample),
    .raddr_i (addr),
    .rdata_o (rd_data)
  );

  ctrl ctrl_i (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .set_cnt_i (set_cnt_i),
    .cmd_i     (cmd_i),
    .run_i     (run_i),
    .stb_i     (stb),
    .we_o      (we),
    .addr_o    (addr),
    .tx_rdy_i  (tx_rdy),
    .tx_stb_o  (tx_stb),
    .busy_o    (busy_o)
  );

  la_uart_tx uart_i (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .stb_i  (tx_stb),
    .data_i (rd_data),
    .rdy_o  (tx_rdy),
    .tx_o   (tx_o)
  );

endmodule

`default_nettype wire

// File: la_uart_tx.sv
// la_uart_tx: 8N1 serial transmitter with ready flag
`default_nettype none
`timescale 1ns/100ps

module la_uart_tx import la_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_in,     // sync, active low
  input  wire logic                stb_i,      // start frame, only while rdy_o
  input  wire logic [SAMPLE_W-1:0] data_i,     // byte, latched with stb_i
  output logic                     rdy_o,      // high only in U_IDLE
  output logic                     tx_o        // serial line, idle high
);

  uart_state_t         state_q;
  logic [BAUD_W-1:0]   baud_q;                 // cycles within a bit
  logic [BIT_W-1:0]    bit_q;                  // data bit index
  logic [SAMPLE_W-1:0] shr_q;                  // data, shifted out LSB first
  logic                bit_end;

  assign bit_end = (baud_q == BAUD_W'(BAUD_DIV - 1));
  assign rdy_o   = (state_q == U_IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= U_IDLE;
      baud_q  <= '0;
      bit_q   <= '0;
      tx_o    <= 1'b1;
    end else begin
      baud_q <= (state_q == U_IDLE || bit_end) ? '0 : baud_q + 1'b1;
      case (state_q)
        U_IDLE: begin
          if (stb_i) begin
            tx_o    <= 1'b0;                   // start bit
            state_q <= U_START;
          end
        end
        U_START: begin
          if (bit_end) begin
            tx_o    <= shr_q[0];               // bit 0
            bit_q   <= '0;
            state_q <= U_DATA;
          end
        end
        U_DATA: begin
          if (bit_end) begin
            if (bit_q == BIT_W'(SAMPLE_W - 1)) begin
              tx_o    <= 1'b1;                 // stop bit
              state_q <= U_STOP;
            end else begin
              tx_o  <= shr_q[1];               // next bit before shift
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        U_STOP: begin
          if (bit_end) begin
            state_q <= U_IDLE;                 // ready again
          end
        end
        default: state_q <= U_IDLE;
      endcase
    end
  end

  // shift register, loaded on accepted strobe
  always_ff @(posedge clk_i) begin
    if (state_q == U_IDLE && stb_i) begin
      shr_q <= data_i;
    end else if (state_q == U_DATA && bit_end) begin
      shr_q <= {1'b0, shr_q[SAMPLE_W-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: ctrl.sv
// ctrl: capture and readout fsm, ring pointer, latched sample counts
`default_nettype none
`timescale 1ns/100ps

module ctrl import la_pkg::*; (
  input  wire logic             clk_i,
  input  wire logic             rst_in,        // sync, active low
  input  wire logic             set_cnt_i,     // latch cmd_i
  input  wire cnt_cfg_t         cmd_i,         // dly_cnt / rd_cnt
  input  wire logic             run_i,         // arm trigger
  input  wire logic             stb_i,         // sample strobe
  output logic                  we_o,          // ring write enable
  output logic [DEPTH-1:0]      addr_o,        // ring address, write and read
  input  wire logic             tx_rdy_i,      // transmitter idle
  output logic                  tx_stb_o,      // start one frame
  output logic                  busy_o         // capture or readout running
);

  ctrl_state_t state_q, state_d;

  logic [CNT_W-1:0]   rd_cnt_q;                // readout length field
  logic [CNT_W-1:0]   dly_cnt_q;               // post-trigger length field
  logic [CNT_W+3:0]   cnt_q, cnt_d;            // room for 4x a count
  logic [DEPTH-1:0]   ptr_q, ptr_d;            // next write slot
  logic [CNT_W+3:0]   trg_len;                 // (dly_cnt + 2) * 4
  logic [CNT_W+3:0]   rd_len;                  // (rd_cnt + 1) * 4

  // widen before adding so the max count does not wrap
  assign trg_len = {({2'b00, dly_cnt_q} + (CNT_W + 2)'(2)), 2'b00};
  assign rd_len  = {({2'b00, rd_cnt_q} + (CNT_W + 2)'(1)), 2'b00};

  assign addr_o = ptr_q;
  assign busy_o = (state_q != IDLE);

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    ptr_d    = ptr_q;
    we_o     = 1'b0;
    tx_stb_o = 1'b0;

    case (state_q)
      IDLE: begin                              // fill ring ahead of trigger
        if (run_i) begin
          state_d = TRG;
          cnt_d   = (CNT_W + 4)'(1);           // count starts at one
        end
        if (stb_i) begin
          we_o  = 1'b1;
          ptr_d = ptr_q + 1'b1;
        end
      end

      TRG: begin
        if (cnt_q == trg_len) begin
          // enough samples after trigger, step back to newest
          state_d = TX;
          cnt_d   = '0;
          ptr_d   = ptr_q - 1'b1;
        end else if (stb_i) begin
          we_o  = 1'b1;
          cnt_d = cnt_q + 1'b1;
          ptr_d = ptr_q + 1'b1;
        end
      end

      TX: begin                                // one frame per visit
        if (cnt_q == rd_len) begin
          state_d = IDLE;                      // readout done
        end else begin
          tx_stb_o = 1'b1;                     // reads ring at ptr this cycle
          cnt_d    = cnt_q + 1'b1;
          ptr_d    = ptr_q - 1'b1;             // walk backwards, newest first
          state_d  = TX_WAIT;
        end
      end

      TX_WAIT: begin
        if (tx_rdy_i) begin                    // frame finished
          state_d = TX;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      ptr_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      ptr_q   <= ptr_d;
    end
  end

  // counts may change at any time, used from the next compare on
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rd_cnt_q  <= '0;
      dly_cnt_q <= '0;
    end else if (set_cnt_i) begin
      rd_cnt_q  <= cmd_i.rd_cnt;
      dly_cnt_q <= cmd_i.dly_cnt;
    end
  end

endmodule

`default_nettype wire

// File: la_ring_ram.sv
// la_ring_ram: 32 x 8 ring buffer, sync write, async read
`default_nettype none
`timescale 1ns/100ps

module la_ring_ram import la_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                we_i,       // write enable from ctrl
  input  wire logic [DEPTH-1:0]    waddr_i,
  input  wire logic [SAMPLE_W-1:0] wdata_i,    // sampler output
  input  wire logic [DEPTH-1:0]    raddr_i,
  output logic      [SAMPLE_W-1:0] rdata_o     // to transmitter
);

  logic [SAMPLE_W-1:0] mem_q [2**DEPTH];       // contents undefined until written

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // async read so the entry is valid in the tx_stb cycle
  assign rdata_o = mem_q[raddr_i];

endmodule

`default_nettype wire

// File: la_sampler.sv
// la_sampler: sample strobe divider and probe capture register
`default_nettype none
`timescale 1ns/100ps

module la_sampler import la_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_in,     // sync, active low
  input  wire logic [SAMPLE_W-1:0] probe_i,    // probe bus
  output logic                     stb_o,      // one cycle per SAMPLE_DIV
  output logic      [SAMPLE_W-1:0] sample_o    // probe value from last strobe
);

  logic [SDIV_W-1:0] div_q;                    // free-running divider
  logic              div_wrap;

  assign div_wrap = (div_q == SDIV_W'(SAMPLE_DIV - 1));

  // divider restarts at zero, strobe registered off the wrap
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      div_q <= '0;
      stb_o <= 1'b0;
    end else begin
      div_q <= div_wrap ? '0 : div_q + 1'b1;
      stb_o <= div_wrap;                       // first high SAMPLE_DIV cycles in
    end
  end

  // capture on the edge that ends a strobe cycle
  // ring writes this value on the following strobe
  always_ff @(posedge clk_i) begin
    if (stb_o) begin
      sample_o <= probe_i;
    end
  end

endmodule

`default_nettype wire

// File: la_pkg.sv
// la_pkg: sizes, dividers, count config struct, fsm state enums
`default_nettype none

package la_pkg;

  localparam int DEPTH      = 5;              // ring address width, 32 entries
  localparam int SAMPLE_W   = 8;              // probe / sample width
  localparam int CNT_W      = 16;             // width of each count field
  localparam int SAMPLE_DIV = 4;              // clocks per sample strobe
  localparam int BAUD_DIV   = 8;              // clocks per uart bit

  // derived counter widths
  localparam int SDIV_W = $clog2(SAMPLE_DIV); // sample divider counter
  localparam int BAUD_W = $clog2(BAUD_DIV);   // baud counter
  localparam int BIT_W  = $clog2(SAMPLE_W);   // uart data bit index

  // command word, latched on set_cnt
  typedef struct packed {
    logic [CNT_W-1:0] dly_cnt;                // post-trigger length, upper half
    logic [CNT_W-1:0] rd_cnt;                 // readout length, lower half
  } cnt_cfg_t;

  // capture / readout controller
  typedef enum logic [1:0] {
    IDLE,                                     // pre-trigger fill
    TRG,                                      // post-trigger fill
    TX,                                       // issue one frame
    TX_WAIT                                   // wait for transmitter
  } ctrl_state_t;

  // 8N1 transmitter
  typedef enum logic [1:0] {
    U_IDLE,
    U_START,
    U_DATA,
    U_STOP
  } uart_state_t;

endpackage

`default_nettype wire
